// ==== build.f ====
+incdir+.
irq_pkg.sv
data_mem.sv
mem_arbiter.sv
pkt_executor.sv
ie_sequencer.sv
irq_subsys_top.sv
tb_irq_subsys.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_irq_subsys
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_irq_subsys.sv ====
`timescale 1ns/1ps
`include "idt_config.svh"

module tb_irq_subsys;
    import irq_pkg::*;

    localparam int          TMO      = 200;             // Cycles per wait
    localparam int          RUN_TMO  = 20000;           // Cycles for the whole run
    localparam logic [31:0] IDT_BASE = 32'h0000_0400;
    localparam logic [31:0] ESP_IN   = `ESP_RESET - 32'd12;   // After three pushes

    logic        clk;
    logic        arst_n;
    logic        ie_valid;
    logic        ie_ready;
    ie_req_t     ie_req;
    logic        iret_valid;
    logic        iret_ready;
    logic [31:0] idt_base;
    logic        host_valid;
    logic        host_ready;
    mem_req_t    host_mem;
    logic        host_rvalid;
    logic [31:0] host_rdata;
    logic        ctx_valid;
    ctx_t        ctx;
    logic        busy;

    integer      seed;
    int          checks;
    int          errors;
    int          ctx_seen;
    bit          timed_out;
    bit          seq_done;
    ctx_t        exp_q[$];
    ctx_t        exp_c;
    logic [31:0] desc_lo [3];
    logic [31:0] desc_hi [3];
    logic [31:0] shadow [64];       // Host view of words 0 to 63

    irq_subsys_top dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .ie_valid    (ie_valid),
        .ie_ready    (ie_ready),
        .ie_req      (ie_req),
        .iret_valid  (iret_valid),
        .iret_ready  (iret_ready),
        .idt_base    (idt_base),
        .host_valid  (host_valid),
        .host_ready  (host_ready),
        .host_mem    (host_mem),
        .host_rvalid (host_rvalid),
        .host_rdata  (host_rdata),
        .ctx_valid   (ctx_valid),
        .ctx         (ctx),
        .busy        (busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    function automatic ctx_t ref_ie_ctx(input logic [31:0] lo, input logic [31:0] hi,
                                        input ie_req_t req);
        ctx_t c;
        c.cs     = lo[31:16];                   // Gate selector
        c.eip    = {hi[31:16], lo[15:0]};       // Split offset
        c.eflags = req.eflags;
        c.esp    = ESP_IN;
        return c;
    endfunction

    function automatic ctx_t ref_ret_ctx(input ie_req_t req);
        ctx_t c;
        c.cs     = req.cs;
        c.eip    = req.eip;
        c.eflags = req.eflags;
        c.esp    = `ESP_RESET;
        return c;
    endfunction

    function automatic logic [11:0] desc_word(input ie_kind_e kind);
        logic [7:0]  vec;
        logic [31:0] byte_addr;
        vec = (kind == IE_PROT) ? `VEC_PROT : (kind == IE_PF) ? `VEC_PF : `VEC_INT;
        byte_addr = IDT_BASE + {24'd0, vec} * 32'd8;
        return byte_addr[13:2];
    endfunction

    function automatic ie_req_t rand_req(input ie_kind_e kind);
        ie_req_t     r;
        logic [31:0] w;
        r.kind   = kind;
        w        = $random(seed);
        r.eip    = w;
        w        = $random(seed);
        r.cs     = w[15:0];
        r.eflags = w[31:13];
        return r;
    endfunction

    //////////////////////////////////////////////////
    // Checks and handshakes, entered at edge plus 1 ns
    //////////////////////////////////////////////////
    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic fail_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("Timeout while waiting for %s", what);
    endtask

    task automatic host_access(input logic wr, input logic [11:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rd);
        int n;
        host_valid     = 1'b1;
        host_mem.write = wr;
        host_mem.addr  = addr;
        host_mem.wdata = wdata;
        n = 0;
        @(negedge clk);
        while (!host_ready && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (!host_ready) fail_timeout("a host grant");
        @(posedge clk);
        #1;
        host_valid = 1'b0;
        rd = '0;
        if (!wr) begin
            n = 0;
            @(negedge clk);
            while (!host_rvalid && n < TMO) begin
                @(negedge clk);
                n++;
            end
            if (!host_rvalid) fail_timeout("host read data");
            rd = host_rdata;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic issue_ie(input ie_req_t req);
        ie_req   = req;
        ie_valid = 1'b1;
    endtask

    task automatic accept_ie(input ie_req_t req);
        int n;
        n = 0;
        @(negedge clk);
        while (!ie_ready && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (!ie_ready) fail_timeout("ie_ready");
        @(posedge clk);
        #1;
        ie_valid = 1'b0;
        exp_q.push_back(ref_ie_ctx(desc_lo[req.kind], desc_hi[req.kind], req));
    endtask

    task automatic send_iret(input ie_req_t req);
        int n;
        iret_valid = 1'b1;
        n = 0;
        @(negedge clk);
        while (!iret_ready && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (!iret_ready) fail_timeout("iret_ready");
        @(posedge clk);
        #1;
        iret_valid = 1'b0;
        exp_q.push_back(ref_ret_ctx(req));
    endtask

    task automatic wait_ctx(input int target);
        int n;
        n = 0;
        while (ctx_seen < target && n < TMO) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (ctx_seen < target) fail_timeout("a ctx_valid pulse");
    endtask

    // Host reads of the three words pushed on entry
    task automatic check_stack(input ie_req_t req);
        logic [31:0] d;
        logic [11:0] sw;
        sw = ESP_IN[13:2];
        host_access(1'b0, sw, 32'd0, d);
        check("stack[esp] eip", d, req.eip);
        host_access(1'b0, sw + 12'd1, 32'd0, d);
        check("stack[esp+4] cs", d, {16'd0, req.cs});
        host_access(1'b0, sw + 12'd2, 32'd0, d);
        check("stack[esp+8] eflags", d, {13'd0, req.eflags});
    endtask

    // Entry, optional stack readback, then return
    task automatic run_event(input ie_req_t req, input logic read_stack);
        int base;
        base = ctx_seen;
        issue_ie(req);
        accept_ie(req);
        wait_ctx(base + 1);
        if (read_stack) check_stack(req);
        send_iret(req);
        wait_ctx(base + 2);
    endtask

    task automatic host_traffic(input int ops);
        int          i;
        logic [31:0] r;
        logic [31:0] d;
        logic [11:0] a;
        for (i = 0; i < ops; i++) begin
            r = $random(seed);
            a = {6'd0, r[5:0]};
            if (r[31]) begin
                d = $random(seed);
                host_access(1'b1, a, d, r);
                shadow[a[5:0]] = d;
            end else begin
                host_access(1'b0, a, 32'd0, d);
                check($sformatf("host_rdata[%0d]", a), d, shadow[a[5:0]]);
            end
        end
    endtask

    task automatic report_test(input string name, input int err0);
        $display("test %s %s", name, (errors == err0) ? "ok" : "FAILED");
    endtask

    //////////////////////////////////////////////////
    // Compare process and request monitor
    //////////////////////////////////////////////////
    always @(negedge clk) begin
        if (arst_n && ctx_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("A context retired that no request asked for");
            end else begin
                exp_c = exp_q.pop_front();
                check("ctx.cs", {16'd0, ctx.cs}, {16'd0, exp_c.cs});
                check("ctx.eip", ctx.eip, exp_c.eip);
                check("ctx.eflags", {13'd0, ctx.eflags}, {13'd0, exp_c.eflags});
                check("ctx.esp", ctx.esp, exp_c.esp);
            end
            ctx_seen++;
        end
    end

    always @(negedge clk) begin
        if (arst_n && busy && (ie_ready || iret_ready)) begin
            errors++;
            $display("A request ready was high while the sequencer was busy");
        end
    end

    // Run ends when the sequence is done or a wait gave up
    initial begin
        int n;
        n = 0;
        while (!seq_done && !timed_out && n < RUN_TMO) begin
            @(posedge clk);
            n++;
        end
        if (!seq_done && !timed_out) begin
            errors++;
            $display("The test sequence did not finish in time");
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        int          k;
        int          err0;
        int          base;
        logic [31:0] d;
        ie_req_t     req_a;
        ie_req_t     req_b;
        seed       = 32'hc102a375;
        checks     = 0;
        errors     = 0;
        ctx_seen   = 0;
        arst_n     = 1'b0;
        ie_valid   = 1'b0;
        ie_req     = '0;
        iret_valid = 1'b0;
        idt_base   = IDT_BASE;
        host_valid = 1'b0;
        host_mem   = '0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        for (k = 0; k < 3; k++) begin
            desc_lo[k] = $random(seed);
            desc_hi[k] = $random(seed);
            host_access(1'b1, desc_word(ie_kind_e'(k)), desc_lo[k], d);
            host_access(1'b1, desc_word(ie_kind_e'(k)) + 12'd1, desc_hi[k], d);
        end

        for (k = 0; k < 3; k++) begin
            err0  = errors;
            req_a = rand_req(ie_kind_e'(k));
            run_event(req_a, 1'b1);
            report_test($sformatf("entry/stack/return kind %0d", k), err0);
        end

        // Second request held while the first one is serviced
        err0  = errors;
        base  = ctx_seen;
        req_a = rand_req(IE_INT);
        req_b = rand_req(IE_PROT);
        check("iret_ready", {31'd0, iret_ready}, 32'd0);
        check("busy", {31'd0, busy}, 32'd0);
        issue_ie(req_a);
        accept_ie(req_a);
        check("busy", {31'd0, busy}, 32'd1);
        issue_ie(req_b);
        wait_ctx(base + 1);
        check("ie_ready", {31'd0, ie_ready}, 32'd0);
        check("iret_ready", {31'd0, iret_ready}, 32'd1);
        check("busy", {31'd0, busy}, 32'd0);
        send_iret(req_a);
        accept_ie(req_b);
        check("ctx count at queued accept", ctx_seen, base + 2);
        wait_ctx(base + 3);
        send_iret(req_b);
        wait_ctx(base + 4);
        report_test("request gating", err0);

        err0 = errors;
        for (k = 0; k < 64; k++) begin
            d = {~k[11:0], 8'hA5, k[11:0]};
            host_access(1'b1, k[11:0], d, d);
            shadow[k] = {~k[11:0], 8'hA5, k[11:0]};
        end
        req_a = rand_req(IE_PF);
        fork
            run_event(req_a, 1'b0);
            host_traffic(60);
        join
        check_stack(req_a);
        report_test("memory contention", err0);

        seq_done = 1'b1;
    end

endmodule

// ==== irq_subsys_top.sv ====
`timescale 1ns/1ps

module irq_subsys_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                ie_valid,
    output logic                ie_ready,
    input  irq_pkg::ie_req_t    ie_req,
    input  logic                iret_valid,
    output logic                iret_ready,
    input  logic [31:0]         idt_base,
    input  logic                host_valid,
    output logic                host_ready,
    input  irq_pkg::mem_req_t   host_mem,
    output logic                host_rvalid,
    output logic [31:0]         host_rdata,
    output logic                ctx_valid,
    output irq_pkg::ctx_t       ctx,
    output logic                busy
);
    import irq_pkg::*;

    // Sequencer to executor
    logic        pkt_valid;
    logic        pkt_ready;
    pkt_u        pkt;
    wb_slot_e    pkt_slot;
    logic        wb_valid;
    wb_t         wb;

    // Executor memory port
    logic        ex_mem_valid;
    logic        ex_mem_ready;
    mem_req_t    ex_mem;
    logic        ex_rvalid;
    logic [31:0] rdata;

    logic        mem_en;
    mem_req_t    mem_req;
    logic [31:0] mem_rdata;

    ie_sequencer u_seq (
        .clk        (clk),
        .arst_n     (arst_n),
        .ie_valid   (ie_valid),
        .ie_ready   (ie_ready),
        .ie_req     (ie_req),
        .iret_valid (iret_valid),
        .iret_ready (iret_ready),
        .idt_base   (idt_base),
        .pkt_valid  (pkt_valid),
        .pkt_ready  (pkt_ready),
        .pkt        (pkt),
        .pkt_slot   (pkt_slot),
        .wb_valid   (wb_valid),
        .wb         (wb),
        .busy       (busy)
    );

    pkt_executor u_exec (
        .clk        (clk),
        .arst_n     (arst_n),
        .pkt_valid  (pkt_valid),
        .pkt_ready  (pkt_ready),
        .pkt        (pkt),
        .pkt_slot   (pkt_slot),
        .mem_valid  (ex_mem_valid),
        .mem_ready  (ex_mem_ready),
        .mem_req    (ex_mem),
        .rvalid     (ex_rvalid),
        .rdata      (rdata),
        .wb_valid   (wb_valid),
        .wb         (wb),
        .ctx_valid  (ctx_valid),
        .ctx        (ctx)
    );

    mem_arbiter u_arb (
        .clk         (clk),
        .arst_n      (arst_n),
        .ex_valid    (ex_mem_valid),
        .ex_ready    (ex_mem_ready),
        .ex_req      (ex_mem),
        .ex_rvalid   (ex_rvalid),
        .ex_rdata    (rdata),
        .host_valid  (host_valid),
        .host_ready  (host_ready),
        .host_req    (host_mem),
        .host_rvalid (host_rvalid),
        .host_rdata  (host_rdata),
        .mem_en      (mem_en),
        .mem_req     (mem_req),
        .mem_rdata   (mem_rdata)
    );

    data_mem u_mem (
        .clk       (clk),
        .mem_en    (mem_en),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata)
    );

endmodule

// ==== ie_sequencer.sv ====
`timescale 1ns/1ps
`include "idt_config.svh"

module ie_sequencer (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                ie_valid,
    output logic                ie_ready,
    input  irq_pkg::ie_req_t    ie_req,
    input  logic                iret_valid,
    output logic                iret_ready,
    input  logic [31:0]         idt_base,
    output logic                pkt_valid,
    input  logic                pkt_ready,
    output irq_pkg::pkt_u       pkt,
    output irq_pkg::wb_slot_e   pkt_slot,
    input  logic                wb_valid,
    input  irq_pkg::wb_t        wb,
    output logic                busy
);
    import irq_pkg::*;

    // One-hot state indices
    localparam int S_IDLE     = 0;
    localparam int S_PUSH_EF  = 1;
    localparam int S_PUSH_CS  = 2;
    localparam int S_PUSH_EIP = 3;
    localparam int S_MOV_LO   = 4;
    localparam int S_MOV_HI   = 5;
    localparam int S_WAIT     = 6;  // Shared by entry and return
    localparam int S_JMP_IE   = 7;
    localparam int S_IDLE_MID = 8;
    localparam int S_POP_EIP  = 9;
    localparam int S_POP_CS   = 10;
    localparam int S_POP_EF   = 11;
    localparam int S_JMP_RET  = 12;
    localparam logic [12:0] ST_ONE = 13'd1;

    logic [12:0] state_q;
    logic [12:0] state_nx;
    logic        adv;
    logic        wb_hi;
    logic        wb_ef;
    logic [7:0]  vec;
    logic [31:0] desc_addr;
    logic [15:0] cs_q;
    logic [31:0] eip_q;
    logic [18:0] eflags_q;
    logic [31:0] desc_lo_q;
    logic [31:0] desc_hi_q;
    logic [31:0] temp_l_q;
    logic [31:0] temp_h_q;

    assign ie_ready   = state_q[S_IDLE];
    assign iret_ready = state_q[S_IDLE_MID];
    assign busy       = ~(state_q[S_IDLE] | state_q[S_IDLE_MID]);
    assign pkt_valid  = ~(state_q[S_IDLE] | state_q[S_IDLE_MID] | state_q[S_WAIT]);
    assign adv        = pkt_valid & pkt_ready;
    assign wb_hi      = wb_valid && wb.slot == SLOT_TEMP_H;
    assign wb_ef      = wb_valid && wb.slot == SLOT_POP_EF;

    //////////////////////////////////////////////////
    // Descriptor address and context capture
    //////////////////////////////////////////////////
    always_comb begin
        unique case (ie_req.kind)
            IE_PROT: vec = `VEC_PROT;
            IE_PF:   vec = `VEC_PF;
            default: vec = `VEC_INT;
        endcase
    end

    assign desc_addr = idt_base + {21'd0, vec, 3'b000};    // 8-byte gates

    always_ff @(posedge clk) begin
        if (ie_valid && ie_ready) begin
            cs_q      <= ie_req.cs;
            eip_q     <= ie_req.eip;
            eflags_q  <= ie_req.eflags;
            desc_lo_q <= desc_addr;
            desc_hi_q <= desc_addr + 32'd4;
        end
        if (wb_valid && wb.slot == SLOT_TEMP_L) temp_l_q <= wb.data;
        if (wb_hi) temp_h_q <= wb.data;
    end

    //////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////
    always_comb begin
        state_nx = state_q;
        if (ie_valid && ie_ready) begin
            state_nx = ST_ONE << S_PUSH_EF;
        end else if (iret_valid && iret_ready) begin
            state_nx = ST_ONE << S_POP_EIP;
        end else if (state_q[S_WAIT] && wb_hi) begin
            state_nx = ST_ONE << S_JMP_IE;     // Gate high word is in
        end else if (state_q[S_WAIT] && wb_ef) begin
            state_nx = ST_ONE << S_JMP_RET;
        end else if (adv) begin
            if (state_q[S_JMP_IE])
                state_nx = ST_ONE << S_IDLE_MID;
            else if (state_q[S_JMP_RET])
                state_nx = ST_ONE << S_IDLE;
            else if (state_q[S_POP_EF])
                state_nx = ST_ONE << S_WAIT;
            else
                state_nx = state_q << 1;        // Straight packet chain
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ST_ONE << S_IDLE;
        end else begin
            state_q <= state_nx;
        end
    end

    //////////////////////////////////////////////////
    // Packet generation
    //////////////////////////////////////////////////
    always_comb begin
        pkt         = '0;
        pkt.imm.opc = `OPC_NOP;
        pkt_slot    = SLOT_TEMP_L;
        if (state_q[S_PUSH_EF] || state_q[S_PUSH_CS] || state_q[S_PUSH_EIP]) begin
            pkt.imm.opc = `OPC_PUSH;
            if (state_q[S_PUSH_EF]) begin
                pkt.imm.imm = bswap32({13'd0, eflags_q});
                pkt_slot    = SLOT_POP_EF;     // Executor takes live flags
            end else if (state_q[S_PUSH_CS]) begin
                pkt.imm.imm = bswap32({16'd0, cs_q});
            end else begin
                pkt.imm.imm = bswap32(eip_q);
            end
        end else if (state_q[S_MOV_LO] || state_q[S_MOV_HI]) begin
            pkt.mem.opc  = `OPC_MOV;
            pkt.mem.disp = bswap32(state_q[S_MOV_LO] ? desc_lo_q : desc_hi_q);
            pkt_slot     = state_q[S_MOV_LO] ? SLOT_TEMP_L : SLOT_TEMP_H;
        end else if (state_q[S_POP_EIP] || state_q[S_POP_CS] || state_q[S_POP_EF]) begin
            pkt.imm.opc = `OPC_POP;
            if (state_q[S_POP_CS])
                pkt_slot = SLOT_TEMP_H;
            else if (state_q[S_POP_EF])
                pkt_slot = SLOT_POP_EF;
        end else if (state_q[S_JMP_IE]) begin
            pkt.far.opc = `OPC_JMPF;
            pkt.far.off = bswap32({temp_h_q[31:16], temp_l_q[15:0]});
            pkt.far.sel = bswap16(temp_l_q[31:16]);
        end else if (state_q[S_JMP_RET]) begin
            pkt.far.opc = `OPC_JMPF;
            pkt.far.off = bswap32(temp_l_q);   // Popped EIP
            pkt.far.sel = bswap16(temp_h_q[15:0]);
        end
    end

    a_state_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot(state_q));

    a_pkt_hold: assert property (@(posedge clk) disable iff (!arst_n)
        pkt_valid && !pkt_ready |=> pkt_valid && $stable(pkt) && $stable(pkt_slot));

endmodule

// ==== pkt_executor.sv ====
`timescale 1ns/1ps
`include "idt_config.svh"

module pkt_executor (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                pkt_valid,
    output logic                pkt_ready,
    input  irq_pkg::pkt_u       pkt,
    input  irq_pkg::wb_slot_e   pkt_slot,
    output logic                mem_valid,
    input  logic                mem_ready,
    output irq_pkg::mem_req_t   mem_req,
    input  logic                rvalid,
    input  logic [31:0]         rdata,
    output logic                wb_valid,
    output irq_pkg::wb_t        wb,
    output logic                ctx_valid,
    output irq_pkg::ctx_t       ctx
);
    import irq_pkg::*;

    logic        is_push;
    logic        is_pop;
    logic        is_mov;
    logic        is_jmp;
    logic        is_rd;
    logic        needs_mem;
    logic        accept;
    logic        rd_grant;
    logic [31:0] esp_dec;
    logic [31:0] byte_addr;
    logic [31:0] esp_q;
    logic [15:0] cs_q;
    logic [31:0] eip_q;
    logic [18:0] eflags_q;
    logic        rd_pend_q;
    logic        ctx_valid_q;
    wb_slot_e    slot_q;

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////
    assign is_push   = pkt.imm.opc == `OPC_PUSH;
    assign is_pop    = pkt.imm.opc == `OPC_POP;
    assign is_mov    = pkt.mem.opc == `OPC_MOV;
    assign is_jmp    = pkt.far.opc == `OPC_JMPF;
    assign is_rd     = is_pop | is_mov;
    assign needs_mem = is_push | is_rd;     // NOP and unknown retire at once

    // Nothing moves while a load is still in flight
    assign mem_valid = pkt_valid & ~rd_pend_q & needs_mem;
    assign pkt_ready = ~rd_pend_q & (needs_mem ? mem_ready : 1'b1);
    assign accept    = pkt_valid & pkt_ready;
    assign rd_grant  = accept & is_rd;
    assign esp_dec   = esp_q - 32'd4;

    always_comb begin
        if (is_push)
            byte_addr = esp_dec;               // Pre-decrement
        else if (is_pop)
            byte_addr = esp_q;
        else
            byte_addr = bswap32(pkt.mem.disp);
    end

    assign mem_req.write = is_push;
    assign mem_req.addr  = byte_addr[`MEM_AW+1:2];
    assign mem_req.wdata = bswap32(pkt.imm.imm);

    //////////////////////////////////////////////////
    // Architectural registers
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            esp_q       <= `ESP_RESET;
            cs_q        <= '0;
            eip_q       <= '0;
            eflags_q    <= '0;
            rd_pend_q   <= 1'b0;
            ctx_valid_q <= 1'b0;
        end else begin
            rd_pend_q   <= rd_grant;
            ctx_valid_q <= accept & is_jmp;
            if (accept && is_push)
                esp_q <= esp_dec;
            else if (accept && is_pop)
                esp_q <= esp_q + 32'd4;
            if (accept && is_jmp) begin
                cs_q  <= bswap16(pkt.far.sel);
                eip_q <= bswap32(pkt.far.off);
            end
            if (accept && is_push && pkt_slot == SLOT_POP_EF)
                eflags_q <= mem_req.wdata[18:0];  // Flags image at entry
            else if (rvalid && slot_q == SLOT_POP_EF)
                eflags_q <= rdata[18:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rd_grant) slot_q <= pkt_slot;      // Target of the pending load
    end

    assign wb_valid   = rvalid;
    assign wb.data    = rdata;
    assign wb.slot    = slot_q;
    assign ctx_valid  = ctx_valid_q;
    assign ctx.cs     = cs_q;
    assign ctx.eip    = eip_q;
    assign ctx.eflags = eflags_q;
    assign ctx.esp    = esp_q;

    // Response arrives next cycle and no second load overlaps it
    a_one_read: assert property (@(posedge clk) disable iff (!arst_n)
        rd_grant |=> rvalid && !rd_grant);

endmodule

// ==== mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                ex_valid,
    output logic                ex_ready,
    input  irq_pkg::mem_req_t   ex_req,
    output logic                ex_rvalid,
    output logic [31:0]         ex_rdata,
    input  logic                host_valid,
    output logic                host_ready,
    input  irq_pkg::mem_req_t   host_req,
    output logic                host_rvalid,
    output logic [31:0]         host_rdata,
    output logic                mem_en,
    output irq_pkg::mem_req_t   mem_req,
    input  logic [31:0]         mem_rdata
);
    logic ex_gnt;
    logic host_gnt;
    logic prio_host_q;      // Round-robin pointer
    logic rd_vld_q;
    logic rd_host_q;        // Owner of the read in flight

    assign ex_gnt   = ex_valid & (~host_valid | ~prio_host_q);
    assign host_gnt = host_valid & (~ex_valid | prio_host_q);

    assign ex_ready   = ex_gnt;
    assign host_ready = host_gnt;
    assign mem_en     = ex_gnt | host_gnt;
    assign mem_req    = ex_gnt ? ex_req : host_req;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prio_host_q <= 1'b0;                // Executor first
            rd_vld_q    <= 1'b0;
            rd_host_q   <= 1'b0;
        end else begin
            if (ex_gnt)
                prio_host_q <= 1'b1;
            else if (host_gnt)
                prio_host_q <= 1'b0;
            rd_vld_q  <= mem_en & ~mem_req.write;
            rd_host_q <= host_gnt;
        end
    end

    // Steer the registered read data back to its requester
    assign ex_rvalid   = rd_vld_q & ~rd_host_q;
    assign host_rvalid = rd_vld_q & rd_host_q;
    assign ex_rdata    = ex_rvalid ? mem_rdata : 32'd0;
    assign host_rdata  = host_rvalid ? mem_rdata : 32'd0;

    a_grant_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(ex_ready && host_ready));

endmodule

// ==== data_mem.sv ====
`timescale 1ns/1ps
`include "idt_config.svh"

module data_mem (
    input  logic                clk,
    input  logic                mem_en,
    input  irq_pkg::mem_req_t   mem_req,
    output logic [31:0]         mem_rdata
);
    logic [31:0] mem [`MEM_WORDS];

    // One access per cycle, read data valid the next cycle
    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_req.write)
                mem[mem_req.addr] <= mem_req.wdata;
            else
                mem_rdata <= mem[mem_req.addr];
        end
    end

endmodule

// ==== irq_pkg.sv ====
`include "idt_config.svh"

package irq_pkg;

    typedef enum logic [1:0] {
        IE_PROT = 2'd0,
        IE_PF   = 2'd1,
        IE_INT  = 2'd2
    } ie_kind_e;

    // Interrupted context as seen at writeback
    typedef struct packed {
        ie_kind_e    kind;
        logic [15:0] cs;
        logic [31:0] eip;
        logic [18:0] eflags;
    } ie_req_t;

    // Pops 0 and 1 land in the same temp slots as the descriptor loads
    typedef enum logic [1:0] {
        SLOT_TEMP_L = 2'd0,
        SLOT_TEMP_H = 2'd1,
        SLOT_POP_EF = 2'd2
    } wb_slot_e;

    //////////////////////////////////////////////////
    // Packet word, first byte at the top
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [7:0]  opc;
        logic [31:0] imm;           // Little-endian
        logic [87:0] pad;
    } pkt_imm_t;

    typedef struct packed {
        logic [15:0] opc;
        logic [31:0] disp;          // Little-endian
        logic [79:0] pad;
    } pkt_mem_t;

    typedef struct packed {
        logic [7:0]  opc;
        logic [31:0] off;
        logic [15:0] sel;
        logic [71:0] pad;
    } pkt_far_t;

    typedef union packed {
        pkt_imm_t imm;
        pkt_mem_t mem;
        pkt_far_t far;
    } pkt_u;

    typedef struct packed {
        logic              write;
        logic [`MEM_AW-1:0] addr;
        logic [31:0]       wdata;
    } mem_req_t;

    typedef struct packed {
        logic [15:0] cs;
        logic [31:0] eip;
        logic [18:0] eflags;
        logic [31:0] esp;
    } ctx_t;

    typedef struct packed {
        logic [31:0] data;
        wb_slot_e    slot;
    } wb_t;

    function automatic logic [31:0] bswap32(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic logic [15:0] bswap16(input logic [15:0] w);
        return {w[7:0], w[15:8]};
    endfunction

endpackage

// ==== idt_config.svh ====
`ifndef IDT_CONFIG_SVH
`define IDT_CONFIG_SVH

//////////////////////////////////////////////////
// Interrupt vectors
//////////////////////////////////////////////////
`define VEC_PROT    8'd13       // General protection
`define VEC_PF      8'd14       // Page fault
`define VEC_INT     8'd15       // External interrupt

//////////////////////////////////////////////////
// Stack and data memory
//////////////////////////////////////////////////
`define ESP_RESET   32'h0000_0F00
`define MEM_WORDS   4096
`define MEM_AW      12          // Word address bits

//////////////////////////////////////////////////
// Packet opcodes
//////////////////////////////////////////////////
`define OPC_PUSH    8'h68       // PUSH imm32
`define OPC_POP     8'h58
`define OPC_NOP     8'h90
`define OPC_JMPF    8'hEA       // JMP ptr16:32
`define OPC_MOV     16'h8B15    // MOV EDX, [disp32]

`endif
